/* Makefile */
VERILATOR ?= verilator
TOP       ?= bulk_fifo_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
FAIL_MSG  ?= Finished with errors

SHELL := /bin/bash

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	set -o pipefail; $(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported errors, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/bulk_fifo_asserts.sv */
module bulk_fifo_asserts (
	input logic                       ti_clk,
	input logic                       rst_n,
	input logic                       rd_en,
	input bulk_fifo_pkg::word_t       rd_data,
	input bulk_fifo_pkg::edge_count_t out_words,
	input bulk_fifo_pkg::fifo_count_t word_count,
	input bulk_fifo_pkg::chunk_op_t   op
);
	import bulk_fifo_pkg::*;

	// Occupancy bounded by the three stages together
	count_in_range: assert property (
		@(posedge ti_clk) disable iff (!rst_n)
		word_count <= fifo_count_t'(FIFO_CAPACITY)
	) else $error("word_count %0d is above the FIFO capacity", word_count);

	// Empty output buffer, so the last word is repeated
	empty_read_holds: assert property (
		@(posedge ti_clk) disable iff (!rst_n)
		(rd_en && out_words == '0) |=> $stable(rd_data)
	) else $error("rd_data changed on a read of an empty FIFO");

	// No chunk traffic while reset is held
	idle_in_reset: assert property (
		@(posedge ti_clk)
		!rst_n |-> (op == OP_NONE)
	) else $error("op is not OP_NONE during reset");

endmodule

/* dv/bulk_fifo_tb.sv */
module bulk_fifo_tb;
	import bulk_fifo_pkg::*;

	localparam int NUM_TESTS = 6;

	logic        ti_clk;
	logic        rst_n;
	logic        wr_en;
	word_t       wr_data;
	logic        rd_en;
	word_t       rd_data;
	fifo_count_t word_count;

	// Name, words written, words read, overlap, word_count at the end
	string test_name [NUM_TESTS] = '{"chunk_multiples", "partial_hold",
		"partial_complete", "overflow_drop", "underflow_repeat", "concurrent_stream"};
	int    wr_words  [NUM_TESTS] = '{40, 6, 2, 300, 0, 200};
	int    rd_words  [NUM_TESTS] = '{40, 5, 4, 288, 3, 150};
	bit    overlap   [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
	int    end_count [NUM_TESTS] = '{0, 2, 0, 0, 0, 50};

	// Reference model of the whole FIFO
	word_t model_q [$];
	word_t last_read;
	int    accepted_total;

	string cur_test;
	int    check_count;
	int    error_count;
	int    test_errors;
	int    failed_tests;

	bulk_fifo_top dut (
		.ti_clk     (ti_clk),
		.rst_n      (rst_n),
		.wr_en      (wr_en),
		.wr_data    (wr_data),
		.rd_en      (rd_en),
		.rd_data    (rd_data),
		.word_count (word_count)
	);

	bind bulk_fifo_top bulk_fifo_asserts u_asserts (
		.ti_clk     (ti_clk),
		.rst_n      (rst_n),
		.rd_en      (rd_en),
		.rd_data    (rd_data),
		.out_words  (out_words),
		.word_count (word_count),
		.op         (op)
	);

	always #10 ti_clk = ~ti_clk;

	////////////////////////////////////////
	// Model and checking
	////////////////////////////////////////

	function automatic void model_write(input word_t w);
		if (model_q.size() < FIFO_CAPACITY) begin
			model_q.push_back(w);
			accepted_total++;
		end
	endfunction

	// A partial chunk stays in the input buffer and cannot be read yet
	function automatic word_t model_read();
		int readable;
		readable = model_q.size() - (accepted_total % WORDS_PER_CHUNK);
		if (readable > 0) begin
			last_read = model_q.pop_front();
		end
		return last_read;
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (expected !== actual) begin
			$display("FAILED %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
			error_count++;
			test_errors++;
		end
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	task automatic next_cycle();
		@(posedge ti_clk);
		#2;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) next_cycle();
	endtask

	task automatic write_words(input int n);
		int    i;
		word_t w;
		for (i = 0; i < n; i++) begin
			w = word_t'($urandom);
			wr_en = 1'b1;
			wr_data = w;
			model_write(w);
			next_cycle();
		end
		wr_en = 1'b0;
	endtask

	// One read every stride cycles, checked once rd_data has loaded
	task automatic read_words(input int n, input int stride);
		int    i;
		word_t exp_w;
		for (i = 0; i < n; i++) begin
			rd_en = 1'b1;
			exp_w = model_read();
			next_cycle();
			rd_en = 1'b0;
			check_value("rd_data", 32'(exp_w), 32'(rd_data));
			idle_cycles(stride - 1);
		end
	endtask

	task automatic run_test(input int t);
		cur_test = test_name[t];
		test_errors = 0;
		if (overlap[t]) begin
			fork
				write_words(wr_words[t]);
				begin
					idle_cycles(40);
					read_words(rd_words[t], 2);
				end
			join
		end else begin
			write_words(wr_words[t]);
			idle_cycles(40);
			check_value("word_count after writes", 32'(model_q.size()), word_count);
			read_words(rd_words[t], 1);
		end
		idle_cycles(40);
		check_value("word_count", 32'(end_count[t]), word_count);
		if (test_errors == 0) begin
			$display("test %s: ok", cur_test);
		end else begin
			$display("test %s: %0d mismatches", cur_test, test_errors);
			failed_tests++;
		end
	endtask

	initial begin : main_seq
		int t;
		void'($urandom(32'h523cfe90));
		ti_clk = 1'b0;
		rst_n = 1'b0;
		wr_en = 1'b0;
		wr_data = '0;
		rd_en = 1'b0;
		last_read = '0;
		accepted_total = 0;
		check_count = 0;
		error_count = 0;
		failed_tests = 0;
		repeat (8) @(posedge ti_clk);
		#2;
		rst_n = 1'b1;
		for (t = 0; t < NUM_TESTS; t++) begin
			run_test(t);
		end
		$display("Tests run: %0d, failed: %0d; checks: %0d, errors: %0d",
			NUM_TESTS, failed_tests, check_count, error_count);
		if (error_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// Eight cycles per table word plus a fixed margin
	initial begin : watchdog
		int limit;
		int t;
		wait (rst_n === 1'b1);
		limit = 2000;
		for (t = 0; t < NUM_TESTS; t++) begin
			limit += (wr_words[t] + rd_words[t]) * 8;
		end
		repeat (limit) @(posedge ti_clk);
		$display("Timeout: test table still running after %0d cycles", limit);
		$display("Finished with errors");
		$finish;
	end

endmodule

/* hw/bulk_fifo_pkg.sv */
package bulk_fifo_pkg;

	////////////////////////////////////////
	// Word and chunk geometry
	////////////////////////////////////////

	localparam int WORD_W          = 16;
	localparam int WORDS_PER_CHUNK = 4;
	localparam int CHUNK_W         = WORD_W * WORDS_PER_CHUNK;
	localparam int WORD_IDX_W      = $clog2(WORDS_PER_CHUNK);

	typedef logic [WORD_W-1:0]  word_t;
	// Word 0 in the low bits, earliest word written
	typedef logic [CHUNK_W-1:0] chunk_t;

	////////////////////////////////////////
	// Depths and capacity
	////////////////////////////////////////

	localparam int IN_CHUNKS     = 4;
	localparam int OUT_CHUNKS    = 4;
	localparam int STORE_CHUNKS  = 64;
	localparam int IN_PTR_W      = $clog2(IN_CHUNKS);
	localparam int OUT_PTR_W     = $clog2(OUT_CHUNKS);
	localparam int STORE_ADDR_W  = $clog2(STORE_CHUNKS);
	localparam int EDGE_COUNT_W  = $clog2(IN_CHUNKS * WORDS_PER_CHUNK + 1);
	localparam int STORE_COUNT_W = $clog2(STORE_CHUNKS + 1);
	localparam int FIFO_CAPACITY = (IN_CHUNKS + STORE_CHUNKS + OUT_CHUNKS) * WORDS_PER_CHUNK;

	typedef logic [STORE_ADDR_W-1:0]  chunk_addr_t;
	typedef logic [EDGE_COUNT_W-1:0]  edge_count_t;
	typedef logic [STORE_COUNT_W-1:0] store_count_t;
	typedef logic [31:0]              fifo_count_t;

	// Scheduler states
	typedef enum logic [1:0] {
		SCHED_IDLE,
		SCHED_STORE,
		SCHED_FETCH,
		SCHED_FETCH_WAIT
	} sched_state_t;

	// Chunk operations seen by the store, pointers and edge buffers
	typedef enum logic [1:0] {
		OP_NONE,
		OP_STORE,
		OP_FETCH
	} chunk_op_t;

endpackage

/* hw/bulk_fifo_top.sv */
module bulk_fifo_top (
	input  logic                       ti_clk,
	input  logic                       rst_n,
	input  logic                       wr_en,
	input  bulk_fifo_pkg::word_t       wr_data,
	input  logic                       rd_en,
	output bulk_fifo_pkg::word_t       rd_data,
	output bulk_fifo_pkg::fifo_count_t word_count
);
	import bulk_fifo_pkg::*;

	chunk_op_t    op;
	logic         chunk_ready;
	logic         chunk_push;
	chunk_t       in_chunk;
	chunk_t       rd_chunk;
	chunk_addr_t  wr_addr;
	chunk_addr_t  rd_addr;
	store_count_t store_chunks;
	logic         store_full;
	logic         store_empty;
	logic         out_room;
	edge_count_t  in_words;
	edge_count_t  out_words;

	////////////////////////////////////////
	// Datapath stages
	////////////////////////////////////////

	word_packer u_packer (
		.ti_clk      (ti_clk),
		.rst_n       (rst_n),
		.wr_en       (wr_en),
		.wr_data     (wr_data),
		.op          (op),
		.chunk_ready (chunk_ready),
		.in_chunk    (in_chunk),
		.in_words    (in_words)
	);

	chunk_store u_store (
		.ti_clk   (ti_clk),
		.op       (op),
		.wr_addr  (wr_addr),
		.rd_addr  (rd_addr),
		.in_chunk (in_chunk),
		.rd_chunk (rd_chunk)
	);

	ring_pointers u_pointers (
		.ti_clk       (ti_clk),
		.rst_n        (rst_n),
		.op           (op),
		.wr_addr      (wr_addr),
		.rd_addr      (rd_addr),
		.store_chunks (store_chunks),
		.store_full   (store_full),
		.store_empty  (store_empty)
	);

	transfer_fsm u_fsm (
		.ti_clk      (ti_clk),
		.rst_n       (rst_n),
		.chunk_ready (chunk_ready),
		.store_full  (store_full),
		.store_empty (store_empty),
		.out_room    (out_room),
		.op          (op),
		.chunk_push  (chunk_push)
	);

	word_unpacker u_unpacker (
		.ti_clk     (ti_clk),
		.rst_n      (rst_n),
		.op         (op),
		.chunk_push (chunk_push),
		.rd_chunk   (rd_chunk),
		.rd_en      (rd_en),
		.rd_data    (rd_data),
		.out_room   (out_room),
		.out_words  (out_words)
	);

	////////////////////////////////////////
	// Occupancy monitor
	////////////////////////////////////////

	// A chunk between fetch and push is briefly left out of the sum
	always_ff @(posedge ti_clk or negedge rst_n) begin
		if (!rst_n) begin
			word_count <= '0;
		end else begin
			word_count <= fifo_count_t'(in_words)
				+ fifo_count_t'({store_chunks, {WORD_IDX_W{1'b0}}})
				+ fifo_count_t'(out_words);
		end
	end

endmodule

/* hw/chunk_store.sv */
module chunk_store (
	input  logic                       ti_clk,
	input  bulk_fifo_pkg::chunk_op_t   op,
	input  bulk_fifo_pkg::chunk_addr_t wr_addr,
	input  bulk_fifo_pkg::chunk_addr_t rd_addr,
	input  bulk_fifo_pkg::chunk_t      in_chunk,
	output bulk_fifo_pkg::chunk_t      rd_chunk
);
	import bulk_fifo_pkg::*;

	// Bulk of the FIFO, a plain single-clock RAM
	chunk_t mem [STORE_CHUNKS];

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////

	always_ff @(posedge ti_clk) begin
		if (op == OP_STORE) begin
			mem[wr_addr] <= in_chunk;
		end
	end

	////////////////////////////////////////
	// Registered read port
	////////////////////////////////////////

	// Data is valid the cycle after OP_FETCH
	always_ff @(posedge ti_clk) begin
		if (op == OP_FETCH) begin
			rd_chunk <= mem[rd_addr];
		end
	end

endmodule

/* hw/ring_pointers.sv */
module ring_pointers (
	input  logic                        ti_clk,
	input  logic                        rst_n,
	input  bulk_fifo_pkg::chunk_op_t    op,
	output bulk_fifo_pkg::chunk_addr_t  wr_addr,
	output bulk_fifo_pkg::chunk_addr_t  rd_addr,
	output bulk_fifo_pkg::store_count_t store_chunks,
	output logic                        store_full,
	output logic                        store_empty
);
	import bulk_fifo_pkg::*;

	assign store_full  = (store_chunks == store_count_t'(STORE_CHUNKS));
	assign store_empty = (store_chunks == '0);

	////////////////////////////////////////
	// Circular addresses and chunk count
	////////////////////////////////////////

	// Addresses wrap on their own since the depth is a power of two
	always_ff @(posedge ti_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_addr      <= '0;
			rd_addr      <= '0;
			store_chunks <= '0;
		end else begin
			case (op)
				OP_STORE: begin
					wr_addr      <= wr_addr + 1'b1;
					store_chunks <= store_chunks + 1'b1;
				end
				OP_FETCH: begin
					rd_addr      <= rd_addr + 1'b1;
					store_chunks <= store_chunks - 1'b1;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

/* hw/transfer_fsm.sv */
module transfer_fsm (
	input  logic                     ti_clk,
	input  logic                     rst_n,
	input  logic                     chunk_ready,
	input  logic                     store_full,
	input  logic                     store_empty,
	input  logic                     out_room,
	output bulk_fifo_pkg::chunk_op_t op,
	output logic                     chunk_push
);
	import bulk_fifo_pkg::*;

	sched_state_t state;
	sched_state_t nxt_state;
	chunk_op_t    last_op;
	logic         can_store;
	logic         can_fetch;

	assign can_store = chunk_ready && !store_full;
	assign can_fetch = !store_empty && out_room;

	////////////////////////////////////////
	// Next state
	////////////////////////////////////////

	// Flags are settled in IDLE and FETCH_WAIT, so both may start a new transfer
	always_comb begin
		nxt_state = state;
		case (state)
			SCHED_IDLE, SCHED_FETCH_WAIT: begin
				// When both are possible, serve the kind not served last
				if (can_store && (!can_fetch || last_op != OP_STORE)) begin
					nxt_state = SCHED_STORE;
				end else if (can_fetch) begin
					nxt_state = SCHED_FETCH;
				end else begin
					nxt_state = SCHED_IDLE;
				end
			end
			SCHED_STORE: nxt_state = SCHED_IDLE;
			SCHED_FETCH: nxt_state = SCHED_FETCH_WAIT;
			default:     nxt_state = SCHED_IDLE;
		endcase
	end

	always_ff @(posedge ti_clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= SCHED_IDLE;
			last_op <= OP_NONE;
		end else begin
			state <= nxt_state;
			if (op != OP_NONE) begin
				last_op <= op;
			end
		end
	end

	////////////////////////////////////////
	// Outputs decoded from state
	////////////////////////////////////////

	always_comb begin
		case (state)
			SCHED_STORE: op = OP_STORE;
			SCHED_FETCH: op = OP_FETCH;
			default:     op = OP_NONE;
		endcase
	end

	// RAM output is registered by now
	assign chunk_push = (state == SCHED_FETCH_WAIT);

endmodule

/* hw/word_packer.sv */
module word_packer (
	input  logic                       ti_clk,
	input  logic                       rst_n,
	input  logic                       wr_en,
	input  bulk_fifo_pkg::word_t       wr_data,
	input  bulk_fifo_pkg::chunk_op_t   op,
	output logic                       chunk_ready,
	output bulk_fifo_pkg::chunk_t      in_chunk,
	output bulk_fifo_pkg::edge_count_t in_words
);
	import bulk_fifo_pkg::*;

	chunk_t                chunk_buf [IN_CHUNKS];
	logic [IN_PTR_W-1:0]   head;
	logic [IN_PTR_W-1:0]   tail;
	logic [IN_PTR_W:0]     full_chunks;
	logic [WORD_IDX_W-1:0] fill;
	logic                  accept;
	logic                  chunk_done;
	logic                  pop;

	// Complete chunks times four plus the partial chunk
	assign in_words = {full_chunks, fill};

	// Words past 16 are dropped
	assign accept     = wr_en && (in_words != edge_count_t'(IN_CHUNKS * WORDS_PER_CHUNK));
	assign chunk_done = accept && (fill == WORD_IDX_W'(WORDS_PER_CHUNK - 1));
	assign pop        = (op == OP_STORE);

	assign chunk_ready = (full_chunks != '0);
	assign in_chunk    = chunk_buf[head];

	////////////////////////////////////////
	// Chunk assembly
	////////////////////////////////////////

	// Partial chunk is built in the tail slot, one word lane at a time
	always_ff @(posedge ti_clk) begin
		if (accept) begin
			chunk_buf[tail][fill*WORD_W +: WORD_W] <= wr_data;
		end
	end

	always_ff @(posedge ti_clk or negedge rst_n) begin
		if (!rst_n) begin
			head        <= '0;
			tail        <= '0;
			full_chunks <= '0;
			fill        <= '0;
		end else begin
			if (accept) begin
				fill <= fill + 1'b1;
			end
			if (chunk_done) begin
				tail <= tail + 1'b1;
			end
			// Scheduler only issues a store while chunk_ready is high
			if (pop) begin
				head <= head + 1'b1;
			end
			case ({chunk_done, pop})
				2'b10: full_chunks <= full_chunks + 1'b1;
				2'b01: full_chunks <= full_chunks - 1'b1;
				default: begin
				end
			endcase
		end
	end

endmodule

/* hw/word_unpacker.sv */
module word_unpacker (
	input  logic                       ti_clk,
	input  logic                       rst_n,
	input  bulk_fifo_pkg::chunk_op_t   op,
	input  logic                       chunk_push,
	input  bulk_fifo_pkg::chunk_t      rd_chunk,
	input  logic                       rd_en,
	output bulk_fifo_pkg::word_t       rd_data,
	output logic                       out_room,
	output bulk_fifo_pkg::edge_count_t out_words
);
	import bulk_fifo_pkg::*;

	chunk_t                slot_buf [OUT_CHUNKS];
	logic [OUT_PTR_W-1:0]  head;
	logic [OUT_PTR_W-1:0]  tail;
	logic [OUT_PTR_W:0]    filled;
	logic [OUT_PTR_W:0]    reserved;
	logic [OUT_PTR_W:0]    slots_used;
	logic [WORD_IDX_W-1:0] word_idx;
	logic                  read_word;
	logic                  last_word;

	assign read_word = rd_en && (filled != '0);
	assign last_word = read_word && (word_idx == WORD_IDX_W'(WORDS_PER_CHUNK - 1));

	// A fetch in flight already holds its slot
	assign slots_used = filled + reserved;
	assign out_room   = slots_used < (OUT_PTR_W + 1)'(OUT_CHUNKS);

	// Words left in the filled slots, minus those already read from the head
	assign out_words = {filled, {WORD_IDX_W{1'b0}}} - edge_count_t'(word_idx);

	////////////////////////////////////////
	// Slot storage
	////////////////////////////////////////

	always_ff @(posedge ti_clk) begin
		if (chunk_push) begin
			slot_buf[tail] <= rd_chunk;
		end
	end

	////////////////////////////////////////
	// Slot bookkeeping and word output
	////////////////////////////////////////

	always_ff @(posedge ti_clk or negedge rst_n) begin
		if (!rst_n) begin
			head     <= '0;
			tail     <= '0;
			filled   <= '0;
			reserved <= '0;
			word_idx <= '0;
			rd_data  <= '0;
		end else begin
			case ({op == OP_FETCH, chunk_push})
				2'b10: reserved <= reserved + 1'b1;
				2'b01: reserved <= reserved - 1'b1;
				default: begin
				end
			endcase
			case ({chunk_push, last_word})
				2'b10: filled <= filled + 1'b1;
				2'b01: filled <= filled - 1'b1;
				default: begin
				end
			endcase
			if (chunk_push) begin
				tail <= tail + 1'b1;
			end
			// Empty reads leave rd_data holding the last word
			if (read_word) begin
				rd_data  <= slot_buf[head][word_idx*WORD_W +: WORD_W];
				word_idx <= word_idx + 1'b1;
			end
			if (last_word) begin
				head <= head + 1'b1;
			end
		end
	end

endmodule

/* src.f */
hw/bulk_fifo_pkg.sv
hw/word_packer.sv
hw/chunk_store.sv
hw/ring_pointers.sv
hw/transfer_fsm.sv
hw/word_unpacker.sv
hw/bulk_fifo_top.sv
dv/bulk_fifo_asserts.sv
dv/bulk_fifo_tb.sv
